// ==== pipe_pkg.sv ====
package pipe_pkg;

    // register address width for rv32i
    // rv32e builds pass 4 through REG_W instead
    parameter int NUM_REGS_LOG2 = 5;

    // register number, x0 never hazards
    typedef logic [NUM_REGS_LOG2-1:0] reg_addr_t;

    // memory access kind of an instruction
    // both bits low means no access
    typedef logic [1:0] mem_rw_t;

    // bit positions inside mem_rw_t
    parameter int RW_LOAD  = 1;
    parameter int RW_STORE = 0;

    // forwarding mask, one bit per id source
    typedef logic [1:0] fwd_mask_t;

    // bit positions inside fwd_mask_t
    parameter int FWD_RS1 = 1;
    parameter int FWD_RS2 = 0;

    // encoding of an empty slot
    parameter mem_rw_t RW_NONE = 2'b00;

endpackage

// ==== dest_tracker.sv ====
`timescale 1ns/1ns

module dest_tracker #(
    parameter int REG_W = 5
) (
    input  logic                clk,
    input  logic                rst,

    // instruction currently in id
    input  logic                id_valid,
    input  logic [REG_W-1:0]    id_rd,
    input  logic                id_reg_write,
    input  pipe_pkg::mem_rw_t   id_mem_rw,

    // advance control
    input  logic                branch_taken,
    input  logic                mem_stall,
    input  logic                hazard_ex,
    input  logic                hazard_mem,

    // shadow slots
    output logic [REG_W-1:0]    ex_rd,
    output logic                ex_reg_write,
    output logic [REG_W-1:0]    mem_rd,
    output logic                mem_reg_write,
    output pipe_pkg::mem_rw_t   mem_rw,
    output logic [REG_W-1:0]    wb_rd,
    output logic                wb_reg_write
);

    // access kind of the ex slot, only needed to feed mem
    pipe_pkg::mem_rw_t ex_rw;

    // id enters ex only when nothing blocks it
    logic issue;
    assign issue = id_valid && !hazard_ex && !hazard_mem;

    // write flags and access kinds decide whether a slot is live
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_reg_write  <= 1'b0;
            ex_rw         <= pipe_pkg::RW_NONE;
            mem_reg_write <= 1'b0;
            mem_rw        <= pipe_pkg::RW_NONE;
            wb_reg_write  <= 1'b0;
        end else if (!mem_stall) begin
            if (branch_taken) begin
                // killed instructions become bubbles
                ex_reg_write  <= 1'b0;
                ex_rw         <= pipe_pkg::RW_NONE;
                mem_reg_write <= 1'b0;
                mem_rw        <= pipe_pkg::RW_NONE;
                wb_reg_write  <= 1'b0;
            end else begin
                ex_reg_write  <= issue ? id_reg_write : 1'b0;
                ex_rw         <= issue ? id_mem_rw : pipe_pkg::RW_NONE;
                mem_reg_write <= ex_reg_write;
                mem_rw        <= ex_rw;
                wb_reg_write  <= mem_reg_write;
            end
        end
    end

    // register numbers are payload, meaningless in an empty slot
    always_ff @(posedge clk) begin
        if (!mem_stall) begin
            ex_rd  <= id_rd;
            mem_rd <= ex_rd;
            wb_rd  <= mem_rd;
        end
    end

endmodule

// ==== data_hazard.sv ====
`timescale 1ns/1ns

module data_hazard #(
    parameter int REG_W = 5
) (
    // sources read by the instruction in id
    input  logic                  id_valid,
    input  logic [REG_W-1:0]      id_rs1,
    input  logic [REG_W-1:0]      id_rs2,

    // destinations still in flight
    input  logic [REG_W-1:0]      ex_rd,
    input  logic                  ex_reg_write,
    input  logic [REG_W-1:0]      mem_rd,
    input  logic                  mem_reg_write,

    output logic                  hazard_ex,
    output logic                  hazard_mem,
    output pipe_pkg::fwd_mask_t   ex_fwd_mask,
    output pipe_pkg::fwd_mask_t   mem_fwd_mask
);

    // slot is a real producer only if it writes a nonzero register
    logic ex_live;
    logic mem_live;

    assign ex_live  = ex_reg_write && (ex_rd != '0);
    assign mem_live = mem_reg_write && (mem_rd != '0);

    // per source match against the ex slot
    always_comb begin
        ex_fwd_mask = '0;
        if (ex_live) begin
            ex_fwd_mask[pipe_pkg::FWD_RS1] = (ex_rd == id_rs1);
            ex_fwd_mask[pipe_pkg::FWD_RS2] = (ex_rd == id_rs2);
        end
    end

    // same for the mem slot
    always_comb begin
        mem_fwd_mask = '0;
        if (mem_live) begin
            mem_fwd_mask[pipe_pkg::FWD_RS1] = (mem_rd == id_rs1);
            mem_fwd_mask[pipe_pkg::FWD_RS2] = (mem_rd == id_rs2);
        end
    end

    // a hazard needs a valid id instruction
    // wb is not compared, regfile writes before it reads
    assign hazard_ex  = id_valid && (|ex_fwd_mask);
    assign hazard_mem = id_valid && (|mem_fwd_mask);

endmodule

// ==== mem_stall.sv ====
`timescale 1ns/1ns

module mem_stall (
    input  logic                clk,
    input  logic                rst,

    // memory handshakes
    input  logic                iready_n,
    input  logic                dready_n,
    input  logic                dbusy,

    // access kind of the mem slot
    input  pipe_pkg::mem_rw_t   mem_rw,

    output logic                mem_stall
);

    typedef enum logic [1:0] {
        ms_idle,
        ms_load_wait,
        ms_store_wait,
        ms_drain
    } ms_state_t;

    ms_state_t state;
    ms_state_t state_nxt;

    logic is_load;
    logic is_store;

    assign is_load  = mem_rw[pipe_pkg::RW_LOAD];
    assign is_store = mem_rw[pipe_pkg::RW_STORE];

    // any access in mem waits behind a draining store
    assign mem_stall = iready_n
                    || (is_load && dready_n)
                    || (is_store && dbusy)
                    || ((state == ms_drain) && (mem_rw != pipe_pkg::RW_NONE) && dbusy);

    always_comb begin
        state_nxt = ms_idle;
        if ((state == ms_drain) && dbusy) begin
            // store still in flight in dmem
            state_nxt = ms_drain;
        end else if (is_store && !mem_stall && dbusy) begin
            // store leaves mem before dmem is done with it
            state_nxt = ms_drain;
        end else if (is_load && dready_n) begin
            state_nxt = ms_load_wait;
        end else if (is_store && dbusy) begin
            state_nxt = ms_store_wait;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ms_idle;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// ==== stage_ctrl.sv ====
`timescale 1ns/1ns

module stage_ctrl (
    input  logic clk,
    input  logic rst,

    // causes
    input  logic branch_taken,
    input  logic mem_stall,
    input  logic hazard_ex,
    input  logic hazard_mem,

    // per stage hold
    output logic stall_id,
    output logic stall_ex,
    output logic stall_mem,
    output logic stall_wb,

    // per stage kill
    output logic nop_if,
    output logic nop_id,
    output logic nop_ex,
    output logic nop_mem,
    output logic nop_wb
);

    // mem hazard needs one more cycle, hold id
    assign stall_id  = mem_stall || hazard_mem;
    // memory wait freezes the back end
    assign stall_ex  = mem_stall;
    assign stall_mem = mem_stall;
    assign stall_wb  = mem_stall;

    // if is held by refetching, so it is killed on any hold
    assign nop_if  = branch_taken || mem_stall || hazard_ex || hazard_mem;
    // ex hazard turns id into a bubble
    assign nop_id  = branch_taken || hazard_ex;
    assign nop_ex  = branch_taken;
    assign nop_mem = branch_taken;

    // killed instruction reaches wb one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            nop_wb <= 1'b0;
        end else begin
            nop_wb <= nop_mem;
        end
    end

endmodule

// ==== pipe_ctrl.sv ====
`timescale 1ns/1ns

module pipe_ctrl #(
    parameter int REG_W = pipe_pkg::NUM_REGS_LOG2
) (
    input  logic                  clk,
    input  logic                  rst,

    // decode report
    input  logic                  id_valid,
    input  logic [REG_W-1:0]      id_rs1,
    input  logic [REG_W-1:0]      id_rs2,
    input  logic [REG_W-1:0]      id_rd,
    input  logic                  id_reg_write,
    input  pipe_pkg::mem_rw_t     id_mem_rw,

    input  logic                  branch_taken,

    // memory status
    input  logic                  iready_n,
    input  logic                  dready_n,
    input  logic                  dbusy,

    output logic                  stall_id,
    output logic                  stall_ex,
    output logic                  stall_mem,
    output logic                  stall_wb,

    output logic                  nop_if,
    output logic                  nop_id,
    output logic                  nop_ex,
    output logic                  nop_mem,
    output logic                  nop_wb,

    output pipe_pkg::fwd_mask_t   ex_fwd_mask,
    output pipe_pkg::fwd_mask_t   mem_fwd_mask
);

    // shadow slot state
    logic [REG_W-1:0]    ex_rd;
    logic                ex_reg_write;
    logic [REG_W-1:0]    mem_rd;
    logic                mem_reg_write;
    pipe_pkg::mem_rw_t   mem_rw;
    logic [REG_W-1:0]    wb_rd;
    logic                wb_reg_write;

    // internal decisions
    logic hazard_ex;
    logic hazard_mem;
    logic mem_wait;

    dest_tracker #(
        .REG_W (REG_W)
    ) u_dest_tracker (
        .clk           (clk),
        .rst           (rst),
        .id_valid      (id_valid),
        .id_rd         (id_rd),
        .id_reg_write  (id_reg_write),
        .id_mem_rw     (id_mem_rw),
        .branch_taken  (branch_taken),
        .mem_stall     (mem_wait),
        .hazard_ex     (hazard_ex),
        .hazard_mem    (hazard_mem),
        .ex_rd         (ex_rd),
        .ex_reg_write  (ex_reg_write),
        .mem_rd        (mem_rd),
        .mem_reg_write (mem_reg_write),
        .mem_rw        (mem_rw),
        .wb_rd         (wb_rd),
        .wb_reg_write  (wb_reg_write)
    );

    data_hazard #(
        .REG_W (REG_W)
    ) u_data_hazard (
        .id_valid      (id_valid),
        .id_rs1        (id_rs1),
        .id_rs2        (id_rs2),
        .ex_rd         (ex_rd),
        .ex_reg_write  (ex_reg_write),
        .mem_rd        (mem_rd),
        .mem_reg_write (mem_reg_write),
        .hazard_ex     (hazard_ex),
        .hazard_mem    (hazard_mem),
        .ex_fwd_mask   (ex_fwd_mask),
        .mem_fwd_mask  (mem_fwd_mask)
    );

    mem_stall u_mem_stall (
        .clk       (clk),
        .rst       (rst),
        .iready_n  (iready_n),
        .dready_n  (dready_n),
        .dbusy     (dbusy),
        .mem_rw    (mem_rw),
        .mem_stall (mem_wait)
    );

    stage_ctrl u_stage_ctrl (
        .clk          (clk),
        .rst          (rst),
        .branch_taken (branch_taken),
        .mem_stall    (mem_wait),
        .hazard_ex    (hazard_ex),
        .hazard_mem   (hazard_mem),
        .stall_id     (stall_id),
        .stall_ex     (stall_ex),
        .stall_mem    (stall_mem),
        .stall_wb     (stall_wb),
        .nop_if       (nop_if),
        .nop_id       (nop_id),
        .nop_ex       (nop_ex),
        .nop_mem      (nop_mem),
        .nop_wb       (nop_wb)
    );

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ns

module tb_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  id_valid,
    input  pipe_pkg::reg_addr_t   id_rs1,
    input  pipe_pkg::reg_addr_t   id_rs2,
    input  pipe_pkg::reg_addr_t   id_rd,
    input  logic                  id_reg_write,
    input  pipe_pkg::mem_rw_t     id_mem_rw,
    input  logic                  branch_taken,
    input  logic                  iready_n,
    input  logic                  dready_n,
    input  logic                  dbusy,
    input  logic                  stall_id,
    input  logic                  stall_ex,
    input  logic                  stall_mem,
    input  logic                  stall_wb,
    input  logic                  nop_if,
    input  logic                  nop_id,
    input  logic                  nop_ex,
    input  logic                  nop_mem,
    input  logic                  nop_wb,
    input  pipe_pkg::fwd_mask_t   ex_fwd_mask,
    input  pipe_pkg::fwd_mask_t   mem_fwd_mask,
    output int                    error_count
);

    // reference copy of the ex and mem slots
    pipe_pkg::reg_addr_t ex_rd_m;
    pipe_pkg::reg_addr_t mem_rd_m;
    logic                ex_wr_m;
    logic                mem_wr_m;
    pipe_pkg::mem_rw_t   ex_rw_m;
    pipe_pkg::mem_rw_t   mem_rw_m;
    // store still busy in dmem after leaving mem
    logic                drain_m;
    logic                nop_wb_m;
    logic [14:0]         want;
    int                  errors = 0;

    assign error_count = errors;

    // {stall id/ex/mem/wb, nop if/id/ex/mem/wb, ex mask, mem mask, hazard ex, hazard mem}
    function automatic logic [14:0] expect_ctrl(
        input logic                valid,
        input pipe_pkg::reg_addr_t rs1,
        input pipe_pkg::reg_addr_t rs2,
        input pipe_pkg::reg_addr_t erd,
        input logic                ewr,
        input pipe_pkg::reg_addr_t mrd,
        input logic                mwr,
        input pipe_pkg::mem_rw_t   mrw,
        input logic                drain,
        input logic                br,
        input logic                irdy_n,
        input logic                drdy_n,
        input logic                busy,
        input logic                nwb
    );
        logic [1:0] exm;
        logic [1:0] memm;
        logic       hx;
        logic       hm;
        logic       ms;
        exm  = 2'b00;
        memm = 2'b00;
        // x0 and non-writing slots never match
        if (ewr && (erd != '0)) begin
            exm = {erd == rs1, erd == rs2};
        end
        if (mwr && (mrd != '0)) begin
            memm = {mrd == rs1, mrd == rs2};
        end
        hx = valid && (|exm);
        hm = valid && (|memm);
        ms = irdy_n || (mrw[1] && drdy_n) || (mrw[0] && busy)
            || (drain && (mrw != 2'b00) && busy);
        return {ms || hm, ms, ms, ms, br || ms || hx || hm, br || hx, br, br, nwb,
                exm, memm, hx, hm};
    endfunction

    assign want = expect_ctrl(id_valid, id_rs1, id_rs2, ex_rd_m, ex_wr_m, mem_rd_m,
                              mem_wr_m, mem_rw_m, drain_m, branch_taken, iready_n,
                              dready_n, dbusy, nop_wb_m);

    // advance the reference slots, want[13] is mem_stall
    always @(posedge clk) begin
        if (rst) begin
            ex_rd_m  <= '0;
            ex_wr_m  <= 1'b0;
            ex_rw_m  <= 2'b00;
            mem_rd_m <= '0;
            mem_wr_m <= 1'b0;
            mem_rw_m <= 2'b00;
            drain_m  <= 1'b0;
            nop_wb_m <= 1'b0;
        end else begin
            nop_wb_m <= branch_taken;
            drain_m  <= (drain_m && dbusy) || (mem_rw_m[0] && !want[13] && dbusy);
            if (!want[13]) begin
                // branch flushes, otherwise mem takes ex
                mem_rd_m <= ex_rd_m;
                mem_wr_m <= branch_taken ? 1'b0 : ex_wr_m;
                mem_rw_m <= branch_taken ? 2'b00 : ex_rw_m;
                ex_rd_m  <= id_rd;
                if (!branch_taken && id_valid && !want[1] && !want[0]) begin
                    ex_wr_m <= id_reg_write;
                    ex_rw_m <= id_mem_rw;
                end else begin
                    ex_wr_m <= 1'b0;
                    ex_rw_m <= 2'b00;
                end
            end
        end
    end

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_mask(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    // inputs change on the rising edge, so compare on the falling one
    always @(negedge clk) begin
        if (!rst) begin
            check_bit("stall_id", want[14], stall_id);
            check_bit("stall_ex", want[13], stall_ex);
            check_bit("stall_mem", want[12], stall_mem);
            check_bit("stall_wb", want[11], stall_wb);
            check_bit("nop_if", want[10], nop_if);
            check_bit("nop_id", want[9], nop_id);
            check_bit("nop_ex", want[8], nop_ex);
            check_bit("nop_mem", want[7], nop_mem);
            check_bit("nop_wb", want[6], nop_wb);
            check_mask("ex_fwd_mask", want[5:4], ex_fwd_mask);
            check_mask("mem_fwd_mask", want[3:2], mem_fwd_mask);
        end
    end

endmodule

// ==== tb_pipe_ctrl.sv ====
`timescale 1ns/1ns

module tb_pipe_ctrl;

    localparam int PHASE_CYCLES = 400;
    localparam int NUM_PHASES   = 5;
    // all phases plus room for reset and phase gaps
    localparam int CYCLE_LIMIT  = NUM_PHASES * PHASE_CYCLES + 200;

    logic                clk          = 1'b0;
    logic                rst          = 1'b1;
    logic                id_valid     = 1'b0;
    pipe_pkg::reg_addr_t id_rs1       = '0;
    pipe_pkg::reg_addr_t id_rs2       = '0;
    pipe_pkg::reg_addr_t id_rd        = '0;
    logic                id_reg_write = 1'b0;
    pipe_pkg::mem_rw_t   id_mem_rw    = 2'b00;
    logic                branch_taken = 1'b0;
    logic                iready_n     = 1'b0;
    logic                dready_n     = 1'b0;
    logic                dbusy        = 1'b0;

    logic                stall_id;
    logic                stall_ex;
    logic                stall_mem;
    logic                stall_wb;
    logic                nop_if;
    logic                nop_id;
    logic                nop_ex;
    logic                nop_mem;
    logic                nop_wb;
    pipe_pkg::fwd_mask_t ex_fwd_mask;
    pipe_pkg::fwd_mask_t mem_fwd_mask;

    int                  error_count;
    int                  cycles        = 0;
    int                  phase_start   = 0;
    int                  phases_passed = 0;
    // stall_id seen before the edge that drives the next instruction
    logic                hold_id       = 1'b0;

    always #5 clk = ~clk;

    pipe_ctrl u_pipe_ctrl (.*);

    tb_checker u_checker (.*);

    always @(negedge clk) begin
        hold_id <= stall_id;
    end

    function automatic string phase_name(input int phase);
        case (phase)
            1:       return "idle after reset";
            2:       return "dependent instructions";
            3:       return "branch flushes";
            4:       return "memory waits";
            default: return "store drain";
        endcase
    endfunction

    // one cycle of stimulus driven right after the rising edge
    task automatic drive_cycle(input int phase);
        int kind;
        kind = int'($urandom % 10);
        if (phase == 4) begin
            iready_n <= ($urandom % 5) == 0;
            dready_n <= ($urandom % 3) == 0;
            dbusy    <= ($urandom % 3) == 0;
        end else begin
            iready_n <= 1'b0;
            dready_n <= 1'b0;
            dbusy    <= (phase == 5) && (($urandom % 10) < 7);
        end
        branch_taken <= (phase == 3) && (($urandom % 6) == 0);
        if (phase == 1) begin
            id_valid <= 1'b0;
        end else if (!hold_id) begin
            // registers 0..3 so that hazards are frequent
            id_valid <= ($urandom % 4) != 0;
            id_rs1   <= pipe_pkg::reg_addr_t'($urandom % 4);
            id_rs2   <= pipe_pkg::reg_addr_t'($urandom % 4);
            id_rd    <= pipe_pkg::reg_addr_t'($urandom % 4);
            if (phase == 5) begin
                kind = 4 + int'($urandom % 6);
            end
            if (kind < 4) begin
                id_mem_rw    <= 2'b00;
                id_reg_write <= ($urandom % 3) != 0;
            end else if (kind < 7) begin
                // store
                id_mem_rw    <= 2'b01;
                id_reg_write <= 1'b0;
            end else begin
                // load
                id_mem_rw    <= 2'b10;
                id_reg_write <= 1'b1;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h4d1b815e));
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int p = 1; p <= NUM_PHASES; p++) begin
            phase_start = error_count;
            repeat (PHASE_CYCLES) begin
                @(posedge clk);
                drive_cycle(p);
            end
            // last driven cycle is compared on this edge
            @(negedge clk);
            // count only once that compare has run
            #1;
            $display("phase %0d %s: %0d errors", p, phase_name(p), error_count - phase_start);
            if (error_count == phase_start) begin
                phases_passed++;
            end
        end
        $display("done: %0d phases passed, %0d failed, %0d errors",
                 phases_passed, NUM_PHASES - phases_passed, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

// ==== build.f ====
pipe_pkg.sv
dest_tracker.sv
data_hazard.sv
mem_stall.sv
stage_ctrl.sv
pipe_ctrl.sv
tb_checker.sv
tb_pipe_ctrl.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/sim: build.f $(wildcard *.sv)
	verilator --binary --timing --timescale 1ns/1ns -j 0 --top-module tb_pipe_ctrl -f build.f -o sim

run: obj_dir/sim
	./obj_dir/sim | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	verilator --lint-only --timing --timescale 1ns/1ns --top-module tb_pipe_ctrl -f build.f

clean:
	rm -rf obj_dir $(LOG)
